//--- Makefile
TOP := tb_exe_unit

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --timing -f list.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module exe_unit

clean:
	rm -rf obj_dir

//--- alu_stage/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import exe_pkg::*; (
    input  exe_op_e op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result,
    output logic    overflow
);

    localparam int msb = word_w - 1;

    word_t    sum;
    word_t    diff;
    logic     add_ovf;
    logic     sub_ovf;
    logic [4:0] sa;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;
    assign sa   = src1[4:0];

    // operands of equal sign, result sign flipped
    assign add_ovf = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
    assign sub_ovf = (src1[msb] != src2[msb]) && (diff[msb] != src1[msb]);

    always_comb begin
        case (op)
            op_add, op_addu:
                result = sum;
            op_lb, op_lh, op_lw, op_sb, op_sh, op_sw:
                result = sum;
            op_sub, op_subu:
                result = diff;
            op_slt:
                result = {{msb{1'b0}}, $signed(src1) < $signed(src2)};
            op_sltu:
                result = {{msb{1'b0}}, src1 < src2};
            op_and: result = src1 & src2;
            op_or:  result = src1 | src2;
            op_xor: result = src1 ^ src2;
            op_nor: result = ~(src1 | src2);
            op_sll: result = src2 << sa;
            op_srl: result = src2 >> sa;
            op_sra: result = $signed(src2) >>> sa;
            op_lui: result = {src2[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_comb begin
        case (op)
            op_add:  overflow = add_ovf;
            op_sub:  overflow = sub_ovf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_stage/alu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module alu_stage import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    stage_if.downstream in,
    stage_if.upstream   out
);

    logic      valid_r;
    alu_item_t item_r;
    exe_op_e   op_r;
    reg_addr_t dest_r;
    logic      gr_we_r;
    exc_code_e exc_r;

    word_t     hi;
    word_t     lo;
    word_t     alu_result;
    logic      overflow;
    logic signed [2*word_w-1:0] prod_s;
    logic [2*word_w-1:0]        prod_u;
    logic [2*word_w-1:0]        product;
    logic      leaving;
    mem_item_t item_out;

    assign in.allowin = !valid_r || out.allowin;
    assign leaving    = valid_r && out.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in.allowin) begin
            valid_r <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            item_r  <= in.payload;
            op_r    <= in.op;
            dest_r  <= in.dest;
            gr_we_r <= in.gr_we;
            exc_r   <= in.exc_code;
        end
    end

    alu u_alu (
        .op       (op_r),
        .src1     (item_r.src1),
        .src2     (item_r.src2),
        .result   (alu_result),
        .overflow (overflow)
    );

    assign prod_s  = $signed({{word_w{item_r.src1[word_w-1]}}, item_r.src1})
                   * $signed({{word_w{item_r.src2[word_w-1]}}, item_r.src2});
    assign prod_u  = {{word_w{1'b0}}, item_r.src1} * {{word_w{1'b0}}, item_r.src2};
    assign product = (op_r == op_mult) ? prod_s : prod_u;

    // HI/LO change only as the writer leaves, so later readers see it
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (leaving) begin
            case (op_r)
                op_mult, op_multu: begin
                    hi <= product[2*word_w-1:word_w];
                    lo <= product[word_w-1:0];
                end
                op_mthi: hi <= item_r.src1;
                op_mtlo: lo <= item_r.src1;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (op_r)
            op_mfhi: item_out.result = hi;
            op_mflo: item_out.result = lo;
            default: item_out.result = alu_result;
        endcase
        item_out.rt_value = item_r.rt_value;
    end

    assign out.valid    = valid_r;
    assign out.payload  = item_out;
    assign out.op       = op_r;
    assign out.dest     = dest_r;
    assign out.gr_we    = gr_we_r;
    assign out.exc_code = overflow ? exc_ov : exc_r;

endmodule

`default_nettype wire

//--- common/exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int word_w = 32;
    localparam int op_w = 5;

    typedef logic [word_w-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [op_w-1:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_mult,
        op_multu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo,
        op_lb,
        op_lh,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } exe_op_e;

    typedef enum logic [1:0] {
        src1_rs,
        src1_sa,
        src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_simm,
        src2_uimm,
        src2_eight
    } src2_sel_e;

    typedef enum logic [4:0] {
        exc_none = 5'h00,
        exc_adel = 5'h04,
        exc_ades = 5'h05,
        exc_ov   = 5'h0c
    } exc_code_e;

    // stage 1 to stage 2
    typedef struct packed {
        word_t src1;
        word_t src2;
        word_t rt_value;
    } alu_item_t;

    // stage 2 to stage 3
    typedef struct packed {
        word_t result;
        word_t rt_value;
    } mem_item_t;

endpackage

`default_nettype wire

//--- common/stage_if.sv
`timescale 1ns/10ps
`default_nettype none

interface stage_if import exe_pkg::*; #(
    parameter type payload_t = word_t
) ();

    logic      valid;
    payload_t  payload;
    logic      allowin;
    exe_op_e   op;
    reg_addr_t dest;
    logic      gr_we;
    exc_code_e exc_code;

    // allowin always comes from the receiving side
    modport upstream (output valid, payload, op, dest, gr_we, exc_code, input allowin);
    modport downstream (input valid, payload, op, dest, gr_we, exc_code, output allowin);

endinterface

`default_nettype wire

//--- list.f
+incdir+testbench
common/exe_pkg.sv
common/stage_if.sv
alu_stage/alu.sv
alu_stage/alu_stage.sv
source/operand_stage.sv
source/mem_request_stage.sv
source/exe_unit.sv
testbench/tb_exe_unit.sv

//--- source/exe_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exe_unit import exe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_allowin,
    input  exe_op_e   in_op,
    input  src1_sel_e in_src1_sel,
    input  src2_sel_e in_src2_sel,
    input  reg_addr_t in_dest,
    input  word_t     in_rs_value,
    input  word_t     in_rt_value,
    input  word_t     in_pc,
    input  logic [15:0] in_imm,
    output logic      out_valid,
    input  logic      out_allowin,
    output exe_op_e   out_op,
    output word_t     out_result,
    output reg_addr_t out_dest,
    output logic      out_gr_we,
    output exc_code_e out_exc_code,
    output word_t     out_bad_vaddr,
    output logic      mem_req,
    output logic      mem_wr,
    output logic [1:0] mem_size,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic [3:0] mem_wstrb,
    input  logic      mem_addr_ok
);

    stage_if #(.payload_t(alu_item_t)) s12 ();
    stage_if #(.payload_t(mem_item_t)) s23 ();

    operand_stage u_operand_stage (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_src1_sel (in_src1_sel),
        .in_src2_sel (in_src2_sel),
        .in_dest     (in_dest),
        .in_rs_value (in_rs_value),
        .in_rt_value (in_rt_value),
        .in_pc       (in_pc),
        .in_imm      (in_imm),
        .in_allowin  (in_allowin),
        .out         (s12.upstream)
    );

    alu_stage u_alu_stage (
        .clk   (clk),
        .reset (reset),
        .in    (s12.downstream),
        .out   (s23.upstream)
    );

    mem_request_stage u_mem_request_stage (
        .clk           (clk),
        .reset         (reset),
        .in            (s23.downstream),
        .out_valid     (out_valid),
        .out_allowin   (out_allowin),
        .out_op        (out_op),
        .out_result    (out_result),
        .out_dest      (out_dest),
        .out_gr_we     (out_gr_we),
        .out_exc_code  (out_exc_code),
        .out_bad_vaddr (out_bad_vaddr),
        .mem_req       (mem_req),
        .mem_wr        (mem_wr),
        .mem_size      (mem_size),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_addr_ok   (mem_addr_ok)
    );

endmodule

`default_nettype wire

//--- source/mem_request_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_request_stage import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    stage_if.downstream in,
    output logic        out_valid,
    input  logic        out_allowin,
    output exe_op_e     out_op,
    output word_t       out_result,
    output reg_addr_t   out_dest,
    output logic        out_gr_we,
    output exc_code_e   out_exc_code,
    output word_t       out_bad_vaddr,
    output logic        mem_req,
    output logic        mem_wr,
    output logic [1:0]  mem_size,
    output word_t       mem_addr,
    output word_t       mem_wdata,
    output logic [3:0]  mem_wstrb,
    input  logic        mem_addr_ok
);

    logic      valid_r;
    mem_item_t item_r;
    exe_op_e   op_r;
    reg_addr_t dest_r;
    logic      gr_we_r;
    exc_code_e exc_r;
    logic      accepted_r;

    word_t     addr;
    logic      is_load;
    logic      is_store;
    logic      misaligned;
    logic      has_exc;
    logic      needs_req;
    logic      ready_go;

    assign addr = item_r.result;

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        mem_size   = 2'd2;
        mem_wdata  = item_r.rt_value;
        mem_wstrb  = 4'b0000;
        case (op_r)
            op_lb: begin
                is_load  = 1'b1;
                mem_size = 2'd0;
            end
            op_lh: begin
                is_load    = 1'b1;
                mem_size   = 2'd1;
                misaligned = addr[0];
            end
            op_lw: begin
                is_load    = 1'b1;
                misaligned = addr[1:0] != 2'b00;
            end
            op_sb: begin
                is_store  = 1'b1;
                mem_size  = 2'd0;
                mem_wdata = {4{item_r.rt_value[7:0]}};
                mem_wstrb = 4'b0001 << addr[1:0];
            end
            op_sh: begin
                is_store   = 1'b1;
                mem_size   = 2'd1;
                mem_wdata  = {2{item_r.rt_value[15:0]}};
                mem_wstrb  = addr[1] ? 4'b1100 : 4'b0011;
                misaligned = addr[0];
            end
            op_sw: begin
                is_store   = 1'b1;
                mem_wstrb  = 4'b1111;
                misaligned = addr[1:0] != 2'b00;
            end
            default: ;
        endcase
    end

    // earlier exception wins over misalignment
    always_comb begin
        if (exc_r != exc_none) begin
            out_exc_code = exc_r;
        end else if (misaligned) begin
            out_exc_code = is_store ? exc_ades : exc_adel;
        end else begin
            out_exc_code = exc_none;
        end
    end

    assign has_exc   = out_exc_code != exc_none;
    assign needs_req = (is_load || is_store) && !has_exc;
    assign mem_req   = valid_r && needs_req && !accepted_r;
    assign ready_go  = !needs_req || accepted_r || mem_addr_ok;

    assign in.allowin = !valid_r || (ready_go && out_allowin);
    assign out_valid  = valid_r && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in.allowin) begin
            valid_r <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            item_r  <= in.payload;
            op_r    <= in.op;
            dest_r  <= in.dest;
            gr_we_r <= in.gr_we;
            exc_r   <= in.exc_code;
        end
    end

    // request taken but item still stuck behind out_allowin
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted_r <= 1'b0;
        end else if (out_valid && out_allowin) begin
            accepted_r <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            accepted_r <= 1'b1;
        end
    end

    assign mem_wr        = is_store;
    assign mem_addr      = addr;
    assign out_op        = op_r;
    assign out_result    = item_r.result;
    assign out_dest      = dest_r;
    assign out_gr_we     = gr_we_r && !has_exc;
    assign out_bad_vaddr = addr;

endmodule

`default_nettype wire

//--- source/operand_stage.sv
`timescale 1ns/10ps
`default_nettype none

module operand_stage import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  exe_op_e     in_op,
    input  src1_sel_e   in_src1_sel,
    input  src2_sel_e   in_src2_sel,
    input  reg_addr_t   in_dest,
    input  word_t       in_rs_value,
    input  word_t       in_rt_value,
    input  word_t       in_pc,
    input  logic [15:0] in_imm,
    output logic        in_allowin,
    stage_if.upstream   out
);

    logic        valid_r;
    exe_op_e     op_r;
    src1_sel_e   src1_sel_r;
    src2_sel_e   src2_sel_r;
    reg_addr_t   dest_r;
    word_t       rs_r;
    word_t       rt_r;
    word_t       pc_r;
    logic [15:0] imm_r;
    alu_item_t   item;

    // always ready to go
    assign in_allowin = !valid_r || out.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in_allowin) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r       <= in_op;
            src1_sel_r <= in_src1_sel;
            src2_sel_r <= in_src2_sel;
            dest_r     <= in_dest;
            rs_r       <= in_rs_value;
            rt_r       <= in_rt_value;
            pc_r       <= in_pc;
            imm_r      <= in_imm;
        end
    end

    always_comb begin
        case (src1_sel_r)
            src1_sa: item.src1 = {{(word_w-5){1'b0}}, imm_r[10:6]};
            src1_pc: item.src1 = pc_r;
            default: item.src1 = rs_r;
        endcase
        case (src2_sel_r)
            src2_simm:  item.src2 = {{(word_w-16){imm_r[15]}}, imm_r};
            src2_uimm:  item.src2 = {{(word_w-16){1'b0}}, imm_r};
            src2_eight: item.src2 = word_t'(8);
            default:    item.src2 = rt_r;
        endcase
        item.rt_value = rt_r;
    end

    // no register write for stores and HI/LO writers
    always_comb begin
        case (op_r)
            op_sb, op_sh, op_sw, op_mult, op_multu, op_mthi, op_mtlo: out.gr_we = 1'b0;
            default: out.gr_we = 1'b1;
        endcase
    end

    assign out.valid    = valid_r;
    assign out.payload  = item;
    assign out.op       = op_r;
    assign out.dest     = dest_r;
    assign out.exc_code = exc_none;

endmodule

`default_nettype wire

//--- testbench/exe_model.svh
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

typedef struct packed {
    exe_op_e    op;
    word_t      result;
    reg_addr_t  dest;
    logic       gr_we;
    exc_code_e  exc;
    logic       check_result;
    logic       needs_req;
    logic       wr;
    logic [1:0] size;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
} expect_t;

// HI/LO as seen by instructions in issue order
word_t model_hi;
word_t model_lo;

function automatic expect_t predict(input exe_op_e op, input src1_sel_e s1,
                                    input src2_sel_e s2, input reg_addr_t dest,
                                    input word_t rs, input word_t rt, input word_t pc,
                                    input logic [15:0] imm);
    expect_t     e;
    word_t       a;
    word_t       b;
    logic [32:0] wide;
    logic [63:0] prod;
    logic        mis;
    e = '0;
    mis = 1'b0;
    case (s1)
        src1_sa: a = {27'h0, imm[10:6]};
        src1_pc: a = pc;
        default: a = rs;
    endcase
    case (s2)
        src2_simm:  b = {{16{imm[15]}}, imm};
        src2_uimm:  b = {16'h0000, imm};
        src2_eight: b = 32'd8;
        default:    b = rt;
    endcase
    e.op = op;
    e.dest = dest;
    e.gr_we = 1'b1;
    e.exc = exc_none;
    e.check_result = 1'b1;
    case (op)
        op_add, op_addu: e.result = a + b;
        op_sub, op_subu: e.result = a - b;
        op_slt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_sltu: e.result = (a < b) ? 32'd1 : 32'd0;
        op_and:  e.result = a & b;
        op_or:   e.result = a | b;
        op_xor:  e.result = a ^ b;
        op_nor:  e.result = ~(a | b);
        op_sll:  e.result = b << a[4:0];
        op_srl:  e.result = b >> a[4:0];
        op_sra:  e.result = $signed(b) >>> a[4:0];
        op_lui:  e.result = {b[15:0], 16'h0000};
        op_mfhi: e.result = model_hi;
        op_mflo: e.result = model_lo;
        op_mult, op_multu: begin
            if (op == op_mult) begin
                prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            end else begin
                prod = {32'h0, a} * {32'h0, b};
            end
            model_hi = prod[63:32];
            model_lo = prod[31:0];
            e.gr_we = 1'b0;
            e.check_result = 1'b0;
        end
        op_mthi, op_mtlo: begin
            if (op == op_mthi) begin
                model_hi = a;
            end else begin
                model_lo = a;
            end
            e.gr_we = 1'b0;
            e.check_result = 1'b0;
        end
        default: begin
            // loads and stores
            e.addr = a + b;
            e.result = e.addr;
            e.wr = op inside {op_sb, op_sh, op_sw};
            e.wdata = rt;
            e.size = 2'd2;
            if (op == op_lb || op == op_sb) begin
                e.size = 2'd0;
            end else if (op == op_lh || op == op_sh) begin
                e.size = 2'd1;
                mis = e.addr[0];
            end else begin
                mis = e.addr[1:0] != 2'b00;
            end
            case (op)
                op_sb: begin
                    e.wdata = {4{rt[7:0]}};
                    case (e.addr[1:0])
                        2'd0: e.wstrb = 4'b0001;
                        2'd1: e.wstrb = 4'b0010;
                        2'd2: e.wstrb = 4'b0100;
                        default: e.wstrb = 4'b1000;
                    endcase
                end
                op_sh: begin
                    e.wdata = {2{rt[15:0]}};
                    e.wstrb = e.addr[1] ? 4'b1100 : 4'b0011;
                end
                op_sw: e.wstrb = 4'b1111;
                default: ;
            endcase
            if (e.wr) begin
                e.gr_we = 1'b0;
            end
            if (mis) begin
                e.exc = e.wr ? exc_ades : exc_adel;
                e.gr_we = 1'b0;
            end else begin
                e.needs_req = 1'b1;
            end
        end
    endcase
    // signed overflow from a 33-bit sum
    if (op == op_add || op == op_sub) begin
        if (op == op_add) begin
            wide = {a[31], a} + {b[31], b};
        end else begin
            wide = {a[31], a} - {b[31], b};
        end
        if (wide[32] != wide[31]) begin
            e.exc = exc_ov;
            e.gr_we = 1'b0;
        end
    end
    return e;
endfunction

`endif

//--- testbench/tb_exe_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exe_unit import exe_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_allowin;
    exe_op_e     in_op;
    src1_sel_e   in_src1_sel;
    src2_sel_e   in_src2_sel;
    reg_addr_t   in_dest;
    word_t       in_rs_value;
    word_t       in_rt_value;
    word_t       in_pc;
    logic [15:0] in_imm;
    logic        out_valid;
    logic        out_allowin;
    exe_op_e     out_op;
    word_t       out_result;
    reg_addr_t   out_dest;
    logic        out_gr_we;
    exc_code_e   out_exc_code;
    word_t       out_bad_vaddr;
    logic        mem_req;
    logic        mem_wr;
    logic [1:0]  mem_size;
    word_t       mem_addr;
    word_t       mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok;

    `include "exe_model.svh"

    expect_t exp_q[$];
    expect_t req_q[$];
    int      errors;
    int      timeouts;
    logic    out_held;
    logic    req_held;
    word_t   held_result;
    word_t   held_addr;

    exe_unit dut (.*);

    always #2 clk = ~clk;

    // random back-pressure and slow address acceptance
    always @(posedge clk) begin
        #0.5;
        out_allowin = $urandom_range(0, 3) != 0;
        mem_addr_ok = $urandom_range(0, 2) != 0;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_output();
        expect_t e;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("output transfer with no item outstanding");
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_value("out_op", 32'(out_op), 32'(e.op));
            if (e.check_result) begin
                check_value("out_result", out_result, e.result);
            end
            check_value("out_dest", 32'(out_dest), 32'(e.dest));
            check_value("out_gr_we", 32'(out_gr_we), 32'(e.gr_we));
            check_value("out_exc_code", 32'(out_exc_code), 32'(e.exc));
            if (e.exc == exc_adel || e.exc == exc_ades) begin
                check_value("out_bad_vaddr", out_bad_vaddr, e.addr);
            end
        end
    endtask

    task automatic check_request();
        expect_t e;
        assert (req_q.size() != 0) else begin
            errors++;
            $display("memory request accepted with none outstanding, address %h", mem_addr);
        end
        if (req_q.size() != 0) begin
            e = req_q.pop_front();
            check_value("mem_wr", 32'(mem_wr), 32'(e.wr));
            check_value("mem_size", 32'(mem_size), 32'(e.size));
            check_value("mem_addr", mem_addr, e.addr);
            if (e.wr) begin
                check_value("mem_wdata", mem_wdata, e.wdata);
                check_value("mem_wstrb", 32'(mem_wstrb), 32'(e.wstrb));
            end
        end
    endtask

    // outputs are stable here, the next edge decides the transfers
    always @(negedge clk) begin
        if (reset) begin
            out_held = 1'b0;
            req_held = 1'b0;
        end else begin
            if (out_held) begin
                assert (out_valid) else begin
                    errors++;
                    $display("out_valid dropped while the output was stalled");
                end
                check_value("out_result while stalled", out_result, held_result);
            end
            if (req_held) begin
                assert (mem_req) else begin
                    errors++;
                    $display("mem_req dropped before the address was accepted");
                end
                check_value("mem_addr while waiting", mem_addr, held_addr);
            end
            if (out_valid && out_allowin) begin
                check_output();
            end
            if (mem_req && mem_addr_ok) begin
                check_request();
            end
            out_held = out_valid && !out_allowin;
            held_result = out_result;
            req_held = mem_req && !mem_addr_ok;
            held_addr = mem_addr;
        end
    end

    task automatic send_item(input exe_op_e op, input src1_sel_e s1, input src2_sel_e s2,
                             input reg_addr_t dest, input word_t rs, input word_t rt,
                             input word_t pc, input logic [15:0] imm);
        int      waited;
        logic    taken;
        expect_t e;
        if (timeouts != 0) begin
            return;
        end
        in_valid = 1'b1;
        in_op = op;
        in_src1_sel = s1;
        in_src2_sel = s2;
        in_dest = dest;
        in_rs_value = rs;
        in_rt_value = rt;
        in_pc = pc;
        in_imm = imm;
        waited = 0;
        taken = 1'b0;
        while (!taken && waited < 200) begin
            @(negedge clk);
            taken = in_allowin;
            @(posedge clk);
            #0.5;
            waited++;
        end
        in_valid = 1'b0;
        if (taken) begin
            e = predict(op, s1, s2, dest, rs, rt, pc, imm);
            exp_q.push_back(e);
            if (e.needs_req) begin
                req_q.push_back(e);
            end
        end else begin
            timeouts++;
            $display("timeout: %s item never accepted", op.name());
        end
    endtask

    task automatic quick_send(input exe_op_e op, input src1_sel_e s1, input src2_sel_e s2,
                              input word_t rs, input word_t rt, input logic [15:0] imm);
        send_item(op, s1, s2, 5'd9, rs, rt, 32'h0040_0100, imm);
    endtask

    task automatic send_random();
        exe_op_e     op;
        src1_sel_e   s1;
        src2_sel_e   s2;
        word_t       rs;
        logic [15:0] imm;
        op = exe_op_e'(5'($urandom_range(0, 25)));
        s1 = src1_sel_e'(2'($urandom_range(0, 2)));
        s2 = src2_sel_e'(2'($urandom_range(0, 3)));
        rs = $urandom;
        imm = 16'($urandom);
        if (op inside {op_lb, op_lh, op_lw, op_sb, op_sh, op_sw}) begin
            s1 = src1_rs;
            s2 = src2_simm;
            // mostly aligned
            if ($urandom_range(0, 3) != 0) begin
                rs[1:0] = 2'b00;
                imm[1:0] = 2'b00;
            end
        end
        send_item(op, s1, s2, 5'($urandom), rs, $urandom, $urandom, imm);
    endtask

    task automatic idle_cycles(input int cycles);
        in_valid = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic run_directed();
        quick_send(op_add, src1_rs, src2_rt, 32'h7fff_ffff, 32'h0000_0001, 16'h0);
        quick_send(op_addu, src1_rs, src2_rt, 32'h7fff_ffff, 32'h0000_0001, 16'h0);
        quick_send(op_sub, src1_rs, src2_rt, 32'h8000_0000, 32'h0000_0001, 16'h0);
        quick_send(op_subu, src1_rs, src2_rt, 32'h8000_0000, 32'h0000_0001, 16'h0);
        quick_send(op_add, src1_rs, src2_simm, 32'h7fff_fff0, 32'h0, 16'h0020);
        quick_send(op_mult, src1_rs, src2_rt, 32'hffff_fffb, 32'h0000_0003, 16'h0);
        quick_send(op_mfhi, src1_rs, src2_rt, 32'h0, 32'h0, 16'h0);
        quick_send(op_mflo, src1_rs, src2_rt, 32'h0, 32'h0, 16'h0);
        quick_send(op_multu, src1_rs, src2_rt, 32'hffff_ffff, 32'hffff_ffff, 16'h0);
        quick_send(op_mflo, src1_rs, src2_rt, 32'h0, 32'h0, 16'h0);
        quick_send(op_mfhi, src1_rs, src2_rt, 32'h0, 32'h0, 16'h0);
        quick_send(op_mthi, src1_rs, src2_rt, 32'h1234_5678, 32'h0, 16'h0);
        quick_send(op_mtlo, src1_rs, src2_rt, 32'h9abc_def0, 32'h0, 16'h0);
        quick_send(op_mfhi, src1_rs, src2_rt, 32'h0, 32'h0, 16'h0);
        quick_send(op_mflo, src1_rs, src2_rt, 32'h0, 32'h0, 16'h0);
        quick_send(op_lui, src1_rs, src2_uimm, 32'h0, 32'h0, 16'hbeef);
        quick_send(op_sll, src1_sa, src2_rt, 32'h0, 32'h8000_0001, 16'h0100);
        quick_send(op_sra, src1_sa, src2_rt, 32'h0, 32'h8000_0000, 16'h07c0);
        quick_send(op_add, src1_pc, src2_eight, 32'h0, 32'h0, 16'h0);
        quick_send(op_slt, src1_rs, src2_simm, 32'hffff_ffff, 32'h0, 16'h0001);
        quick_send(op_sltu, src1_rs, src2_simm, 32'hffff_ffff, 32'h0, 16'h0001);
        quick_send(op_sb, src1_rs, src2_simm, 32'h0000_1000, 32'h1122_3344, 16'h0001);
        quick_send(op_sb, src1_rs, src2_simm, 32'h0000_1000, 32'h1122_3344, 16'h0003);
        quick_send(op_sh, src1_rs, src2_simm, 32'h0000_1000, 32'haabb_ccdd, 16'h0002);
        quick_send(op_sw, src1_rs, src2_simm, 32'h0000_1000, 32'h5566_7788, 16'hfffc);
        quick_send(op_lb, src1_rs, src2_simm, 32'h0000_1000, 32'h0, 16'h0007);
        quick_send(op_lh, src1_rs, src2_simm, 32'h0000_1000, 32'h0, 16'h0006);
        quick_send(op_lw, src1_rs, src2_simm, 32'h0000_1000, 32'h0, 16'h0008);
        // misaligned, no request expected
        quick_send(op_lh, src1_rs, src2_simm, 32'h0000_1000, 32'h0, 16'h0001);
        quick_send(op_lw, src1_rs, src2_simm, 32'h0000_1000, 32'h0, 16'h0002);
        quick_send(op_sh, src1_rs, src2_simm, 32'h0000_1000, 32'h1, 16'h0003);
        quick_send(op_sw, src1_rs, src2_simm, 32'h0000_1000, 32'h1, 16'h0001);
    endtask

    initial begin
        int waited;
        void'($urandom(32'h5f20b7a0));
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = op_add;
        in_src1_sel = src1_rs;
        in_src2_sel = src2_rt;
        in_dest = '0;
        in_rs_value = '0;
        in_rt_value = '0;
        in_pc = '0;
        in_imm = '0;
        out_allowin = 1'b0;
        mem_addr_ok = 1'b0;
        errors = 0;
        timeouts = 0;
        model_hi = '0;
        model_lo = '0;
        repeat (3) @(posedge clk);
        #0.5;
        reset = 1'b0;

        @(negedge clk);
        assert (in_allowin && !out_valid && !mem_req) else begin
            errors++;
            $display("handshake outputs not idle after reset");
        end
        @(posedge clk);
        #0.5;

        run_directed();
        for (int i = 0; i < 600 && timeouts == 0; i++) begin
            send_random();
            if ($urandom_range(0, 7) == 0) begin
                idle_cycles($urandom_range(1, 3));
            end
        end

        // drain what is still in flight
        in_valid = 1'b0;
        waited = 0;
        while ((exp_q.size() != 0 || req_q.size() != 0) && waited < 2000) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (exp_q.size() != 0 || req_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d results and %0d requests still outstanding",
                     exp_q.size(), req_q.size());
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
